/* hdl/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// channel count and datapath widths
`define DMA_NUM_CH          4
`define DMA_WORD_W          32
`define DMA_PRIO_W          3      // dpcr field is this plus the enable bit
`define DMA_ADDR_STEP       4      // bytes per word

// chcr fields
`define DMA_CHCR_DIR_BIT    0      // 1 = memory to device
`define DMA_CHCR_MODE_LO    9      // sync mode in 10:9
`define DMA_CHCR_BUSY_BIT   24
`define DMA_SYNC_BLOCK      1

// bcr block count in 31:16
`define DMA_BCR_CNT_LO      16

// dicr layout
`define DMA_DICR_FORCE_BIT  15
`define DMA_DICR_EN_LO      16
`define DMA_DICR_MASTER_BIT 23
`define DMA_DICR_FLAG_LO    24
`define DMA_DICR_SUM_BIT    31

`endif

/* hdl/dma_pkg.sv */
`include "dma_cfg.svh"

package dma_pkg;

   // one data or address word
   typedef logic [`DMA_WORD_W-1:0] word_t;

   // channel index and per-channel bit vector
   typedef logic [$clog2(`DMA_NUM_CH)-1:0] chan_t;
   typedef logic [`DMA_NUM_CH-1:0] chan_vec_t;

   // what a grant asks the transfer engine to do
   typedef enum logic {
      OP_MOVE   = 1'b0,   // move one word
      OP_FINISH = 1'b1    // block count hit zero so the channel closes
   } xfer_op_e;

   // matches the chcr direction bit
   typedef enum logic {
      DIR_TO_MEM = 1'b0,  // device read, memory write
      DIR_TO_DEV = 1'b1   // memory read, device write
   } xfer_dir_e;

endpackage

/* hdl/dma_if.sv */
`timescale 1ns/10ps

// grant from arbitration to the transfer engine
interface dma_xfer_if;
   logic                 valid;
   logic                 ready;
   dma_pkg::chan_t       chan;
   dma_pkg::xfer_op_e    op;
   dma_pkg::xfer_dir_e   dir;
   dma_pkg::word_t       addr;   // madr of the granted channel

   modport producer (
      output valid, chan, op, dir, addr,
      input  ready
   );

   modport consumer (
      input  valid, chan, op, dir, addr,
      output ready
   );
endinterface

// finished item from the transfer engine to write-back
interface dma_retire_if;
   logic                 valid;
   logic                 ready;
   dma_pkg::chan_t       chan;
   dma_pkg::xfer_op_e    op;
   dma_pkg::xfer_dir_e   dir;

   modport producer (
      output valid, chan, op, dir,
      input  ready
   );

   modport consumer (
      input  valid, chan, op, dir,
      output ready
   );
endinterface

/* hdl/dma_decode.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_decode (
   input  logic                                sys_clk,
   input  logic                                rst,
   input  logic                                dma_en_i,
   input  logic                                retire_i,   // done strobe
   input  dma_pkg::word_t                      dpcr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    chcr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    madr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    bcr_i,
   output logic                                dma_req_o,
   dma_xfer_if.producer                        xfer
);

   localparam int FIELD_W = `DMA_PRIO_W + 1;                  // prio plus enable
   localparam int CNT_W   = `DMA_WORD_W - `DMA_BCR_CNT_LO;

   typedef enum logic [1:0] {ST_IDLE, ST_GRANT, ST_WAIT} state_e;

   state_e                   state_q;
   dma_pkg::chan_vec_t       chan_req;
   logic                     win_found;
   dma_pkg::chan_t           win_chan;
   logic [`DMA_PRIO_W-1:0]   win_prio;
   logic [CNT_W-1:0]         win_cnt;
   logic                     grant_take;
   dma_pkg::chan_t           chan_q;
   dma_pkg::xfer_op_e        op_q;
   dma_pkg::xfer_dir_e       dir_q;
   dma_pkg::word_t           addr_q;

   always_comb begin
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         chan_req[i] = chcr_i[i][`DMA_CHCR_BUSY_BIT] &&
                       (chcr_i[i][`DMA_CHCR_MODE_LO +: 2] == 2'(`DMA_SYNC_BLOCK));
      end
   end

   assign dma_req_o = |chan_req;

   // strict less-than keeps a tie on the lower index
   always_comb begin
      win_found = 1'b0;
      win_chan  = '0;
      win_prio  = '1;
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         if (chan_req[i] && dpcr_i[i*FIELD_W + `DMA_PRIO_W] &&
             (!win_found || dpcr_i[i*FIELD_W +: `DMA_PRIO_W] < win_prio)) begin
            win_found = 1'b1;
            win_chan  = dma_pkg::chan_t'(i);
            win_prio  = dpcr_i[i*FIELD_W +: `DMA_PRIO_W];
         end
      end
   end

   assign win_cnt    = bcr_i[win_chan][`DMA_BCR_CNT_LO +: CNT_W];
   assign grant_take = (state_q == ST_IDLE) && dma_en_i && win_found;

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (grant_take) state_q <= ST_GRANT;
            end
            ST_GRANT: begin
               if (xfer.ready) state_q <= ST_WAIT;   // handshake done
            end
            default: begin
               if (retire_i) state_q <= ST_IDLE;     // one grant in flight
            end
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (grant_take) begin
         chan_q <= win_chan;
         op_q   <= (win_cnt == '0) ? dma_pkg::OP_FINISH : dma_pkg::OP_MOVE;
         dir_q  <= chcr_i[win_chan][`DMA_CHCR_DIR_BIT] ? dma_pkg::DIR_TO_DEV
                                                       : dma_pkg::DIR_TO_MEM;
         addr_q <= madr_i[win_chan];
      end
   end

   assign xfer.valid = (state_q == ST_GRANT);
   assign xfer.chan  = chan_q;
   assign xfer.op    = op_q;
   assign xfer.dir   = dir_q;
   assign xfer.addr  = addr_q;

endmodule

/* hdl/dma_execute.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_execute (
   input  logic                                sys_clk,
   input  logic                                rst,
   dma_xfer_if.consumer                        xfer,
   dma_retire_if.producer                      retire,
   input  dma_pkg::word_t                      mem_rdata_i,
   input  logic                                mem_ack_i,
   output logic                                mem_ren_o,
   output logic                                mem_wen_o,
   output dma_pkg::word_t                      mem_addr_o,
   output dma_pkg::word_t                      mem_wdata_o,
   input  dma_pkg::chan_vec_t                  chan_rdy_i,
   input  dma_pkg::chan_vec_t                  chan_full_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    chan_rdata_i,
   output dma_pkg::chan_vec_t                  chan_ren_o,
   output dma_pkg::chan_vec_t                  chan_wen_o,
   output dma_pkg::word_t [`DMA_NUM_CH-1:0]    chan_wdata_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DEV_RD,     // wait for device ready
      ST_MEM_WR,     // write strobe until ack
      ST_MEM_REL,    // wait for ack to drop
      ST_MEM_RD,     // read strobe until ack
      ST_DEV_WR,     // wait for room in the device
      ST_RETIRE
   } state_e;

   state_e                 state_q;
   dma_pkg::chan_t         chan_q;
   dma_pkg::xfer_op_e      op_q;
   dma_pkg::xfer_dir_e     dir_q;
   dma_pkg::word_t         addr_q;
   dma_pkg::word_t         data_q;   // word held between the two sides
   logic                   accept;
   logic                   dev_rd_go;
   logic                   dev_wr_go;

   assign accept    = xfer.valid && xfer.ready;
   assign dev_rd_go = (state_q == ST_DEV_RD) && chan_rdy_i[chan_q];
   assign dev_wr_go = (state_q == ST_DEV_WR) && !chan_full_i[chan_q];

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  if (xfer.op == dma_pkg::OP_FINISH) begin
                     state_q <= ST_RETIRE;                 // nothing to move
                  end else if (xfer.dir == dma_pkg::DIR_TO_DEV) begin
                     state_q <= ST_MEM_RD;
                  end else begin
                     state_q <= ST_DEV_RD;
                  end
               end
            end
            ST_DEV_RD:  if (dev_rd_go) state_q <= ST_MEM_WR;
            ST_MEM_WR:  if (mem_ack_i) state_q <= ST_MEM_REL;
            ST_MEM_REL: if (!mem_ack_i) state_q <= ST_RETIRE;
            ST_MEM_RD:  if (mem_ack_i) state_q <= ST_DEV_WR;
            ST_DEV_WR:  if (dev_wr_go) state_q <= ST_RETIRE;
            ST_RETIRE:  if (retire.ready) state_q <= ST_IDLE;
            default:    state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (accept) begin
         chan_q <= xfer.chan;
         op_q   <= xfer.op;
         dir_q  <= xfer.dir;
         addr_q <= xfer.addr;
      end
      if (dev_rd_go) begin
         data_q <= chan_rdata_i[chan_q];
      end else if ((state_q == ST_MEM_RD) && mem_ack_i) begin
         data_q <= mem_rdata_i;                             // taken in the ack cycle
      end
   end

   assign xfer.ready   = (state_q == ST_IDLE);
   assign retire.valid = (state_q == ST_RETIRE);
   assign retire.chan  = chan_q;
   assign retire.op    = op_q;
   assign retire.dir   = dir_q;

   assign mem_ren_o   = (state_q == ST_MEM_RD);
   assign mem_wen_o   = (state_q == ST_MEM_WR);
   assign mem_addr_o  = addr_q;
   assign mem_wdata_o = data_q;

   // single-cycle device strobes on the granted lane only
   always_comb begin
      chan_ren_o = '0;
      chan_wen_o = '0;
      chan_ren_o[chan_q] = dev_rd_go;
      chan_wen_o[chan_q] = dev_wr_go;
      for (int i = 0; i < `DMA_NUM_CH; i++) begin
         chan_wdata_o[i] = data_q;
      end
   end

endmodule

/* hdl/dma_result.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_result (
   input  logic                  sys_clk,
   input  logic                  rst,
   dma_retire_if.consumer        retire,
   input  logic                  dicr_wen_i,
   input  dma_pkg::word_t        dicr_wdata_i,
   output dma_pkg::chan_vec_t    madr_incr_o,
   output dma_pkg::chan_vec_t    bcr_decr_o,
   output dma_pkg::chan_vec_t    chcr_clr_o,
   output dma_pkg::chan_vec_t    irq_o,
   output logic                  dma_done_o,
   output dma_pkg::word_t        dicr_o
);

   localparam int N = `DMA_NUM_CH;

   logic                  take;
   dma_pkg::chan_vec_t    chan_sel;
   logic                  is_move;
   dma_pkg::word_t        dicr_q;
   dma_pkg::word_t        dicr_d;

   assign retire.ready = !dma_done_o;                       // gap after each accept
   assign take         = retire.valid && retire.ready;
   assign chan_sel     = dma_pkg::chan_vec_t'(1) << retire.chan;
   assign is_move      = (retire.op == dma_pkg::OP_MOVE);

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         madr_incr_o <= '0;
         bcr_decr_o  <= '0;
         chcr_clr_o  <= '0;
         irq_o       <= '0;
         dma_done_o  <= 1'b0;
      end else begin
         madr_incr_o <= (take && is_move) ? chan_sel : '0;
         bcr_decr_o  <= (take && is_move) ? chan_sel : '0;
         chcr_clr_o  <= (take && !is_move) ? chan_sel : '0;  // drops busy
         irq_o       <= (take && !is_move) ? chan_sel : '0;
         dma_done_o  <= take;
      end
   end

   // interrupt control register
   always_comb begin
      dicr_d = dicr_q;
      dicr_d[`DMA_DICR_SUM_BIT] = dicr_q[`DMA_DICR_FORCE_BIT] |
                                  (|(dicr_q[`DMA_DICR_EN_LO +: N] &
                                     dicr_q[`DMA_DICR_FLAG_LO +: N]));
      if (dicr_wen_i) begin
         dicr_d[5:0] = dicr_wdata_i[5:0];
         dicr_d[`DMA_DICR_FORCE_BIT-1:6] = '0;                      // reads as zero
         dicr_d[`DMA_DICR_MASTER_BIT:`DMA_DICR_FORCE_BIT] =
            dicr_wdata_i[`DMA_DICR_MASTER_BIT:`DMA_DICR_FORCE_BIT];
         dicr_d[`DMA_DICR_FLAG_LO +: N] = dicr_q[`DMA_DICR_FLAG_LO +: N] &
                                          ~dicr_wdata_i[`DMA_DICR_FLAG_LO +: N];  // w1c
      end else if (dicr_q[`DMA_DICR_MASTER_BIT]) begin
         dicr_d[`DMA_DICR_FLAG_LO +: N] = dicr_q[`DMA_DICR_FLAG_LO +: N] |
                                          (dicr_q[`DMA_DICR_EN_LO +: N] & irq_o);
      end
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         dicr_q <= '0;
      end else begin
         dicr_q <= dicr_d;
      end
   end

   assign dicr_o = dicr_q;

endmodule

/* hdl/dma_controller.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_controller (
   input  logic                                sys_clk,
   input  logic                                rst,

   // channel registers live outside and only strobes go back
   input  dma_pkg::word_t                      dpcr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    madr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    bcr_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    chcr_i,
   output dma_pkg::chan_vec_t                  madr_incr_o,
   output dma_pkg::chan_vec_t                  bcr_decr_o,
   output dma_pkg::chan_vec_t                  chcr_clr_o,
   output dma_pkg::chan_vec_t                  irq_o,

   input  logic                                dicr_wen_i,
   input  dma_pkg::word_t                      dicr_wdata_i,
   output dma_pkg::word_t                      dicr_o,

   // bus ownership
   input  logic                                dma_en_i,
   output logic                                dma_req_o,
   output logic                                dma_done_o,

   // memory side
   output logic                                mem_ren_o,
   output logic                                mem_wen_o,
   output dma_pkg::word_t                      mem_addr_o,
   output dma_pkg::word_t                      mem_wdata_o,
   input  dma_pkg::word_t                      mem_rdata_i,
   input  logic                                mem_ack_i,

   // devices
   input  dma_pkg::chan_vec_t                  chan_rdy_i,
   input  dma_pkg::chan_vec_t                  chan_full_i,
   input  dma_pkg::word_t [`DMA_NUM_CH-1:0]    chan_rdata_i,
   output dma_pkg::chan_vec_t                  chan_ren_o,
   output dma_pkg::chan_vec_t                  chan_wen_o,
   output dma_pkg::word_t [`DMA_NUM_CH-1:0]    chan_wdata_o
);

   dma_xfer_if   xfer_if ();
   dma_retire_if retire_if ();

   dma_decode decode_inst (
      .sys_clk   (sys_clk),
      .rst       (rst),
      .dma_en_i  (dma_en_i),
      .retire_i  (dma_done_o),    // release arbitration on done
      .dpcr_i    (dpcr_i),
      .chcr_i    (chcr_i),
      .madr_i    (madr_i),
      .bcr_i     (bcr_i),
      .dma_req_o (dma_req_o),
      .xfer      (xfer_if.producer)
   );

   dma_execute execute_inst (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .xfer         (xfer_if.consumer),
      .retire       (retire_if.producer),
      .mem_rdata_i  (mem_rdata_i),
      .mem_ack_i    (mem_ack_i),
      .mem_ren_o    (mem_ren_o),
      .mem_wen_o    (mem_wen_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o),
      .chan_rdy_i   (chan_rdy_i),
      .chan_full_i  (chan_full_i),
      .chan_rdata_i (chan_rdata_i),
      .chan_ren_o   (chan_ren_o),
      .chan_wen_o   (chan_wen_o),
      .chan_wdata_o (chan_wdata_o)
   );

   dma_result result_inst (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .retire       (retire_if.consumer),
      .dicr_wen_i   (dicr_wen_i),
      .dicr_wdata_i (dicr_wdata_i),
      .madr_incr_o  (madr_incr_o),
      .bcr_decr_o   (bcr_decr_o),
      .chcr_clr_o   (chcr_clr_o),
      .irq_o        (irq_o),
      .dma_done_o   (dma_done_o),
      .dicr_o       (dicr_o)
   );

endmodule

/* test/dma_checker.sv */
`timescale 1ns/10ps

module dma_checker (
   input  logic                  sys_clk,
   input  logic                  rst,
   input  logic                  mem_ren_o,
   input  logic                  mem_wen_o,
   input  dma_pkg::chan_vec_t    chcr_clr_o,
   input  dma_pkg::chan_vec_t    madr_incr_o,
   input  dma_pkg::chan_vec_t    bcr_decr_o
);

   no_dual_strobe: assert property (@(posedge sys_clk) disable iff (rst)
      !(mem_ren_o && mem_wen_o))
      else $error("memory read and write strobes high together");

   clr_onehot: assert property (@(posedge sys_clk) disable iff (rst)
      $onehot0(chcr_clr_o))
      else $error("chcr clear strobe hits more than one channel");

   incr_onehot: assert property (@(posedge sys_clk) disable iff (rst)
      $onehot0(madr_incr_o))
      else $error("madr increment strobe hits more than one channel");

   // address and count always step together
   incr_eq_decr: assert property (@(posedge sys_clk) disable iff (rst)
      madr_incr_o == bcr_decr_o)
      else $error("madr increment and bcr decrement differ");

endmodule

bind dma_controller dma_checker checker_inst (
   .sys_clk     (sys_clk),
   .rst         (rst),
   .mem_ren_o   (mem_ren_o),
   .mem_wen_o   (mem_wen_o),
   .chcr_clr_o  (chcr_clr_o),
   .madr_incr_o (madr_incr_o),
   .bcr_decr_o  (bcr_decr_o)
);

/* test/dma_tb.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_tb;

   localparam int N = `DMA_NUM_CH;
   localparam int TIMEOUT = 4000;                          // 40 per word plus margin
   localparam logic [31:0] BUSY = 32'(1) << `DMA_CHCR_BUSY_BIT;
   localparam logic [31:0] BLOCK = 32'(`DMA_SYNC_BLOCK) << `DMA_CHCR_MODE_LO;
   localparam logic [31:0] TO_MEM = BUSY | BLOCK;
   localparam logic [31:0] TO_DEV = BUSY | BLOCK | (32'(1) << `DMA_CHCR_DIR_BIT);
   localparam logic [31:0] MASTER = 32'(1) << `DMA_DICR_MASTER_BIT;
   localparam logic [31:0] EN1 = 32'(1) << (`DMA_DICR_EN_LO + 1);
   localparam logic [31:0] FLAG1 = 32'(1) << (`DMA_DICR_FLAG_LO + 1);

   logic sys_clk = 1'b0;
   logic rst = 1'b1;
   logic dicr_wen_i, dma_en_i = 1'b0, dma_req_o, dma_done_o;
   logic mem_ren_o, mem_wen_o, mem_ack_i = 1'b0;
   dma_pkg::word_t dpcr_i, dicr_wdata_i, dicr_o, mem_addr_o, mem_wdata_o;
   dma_pkg::word_t mem_rdata_i = '0;
   dma_pkg::word_t [N-1:0] madr_i = '0, bcr_i = '0, chcr_i = '0, chan_rdata_i = '0;
   dma_pkg::word_t [N-1:0] chan_wdata_o;
   dma_pkg::chan_vec_t madr_incr_o, bcr_decr_o, chcr_clr_o, irq_o, chan_ren_o, chan_wen_o;
   dma_pkg::chan_vec_t chan_rdy_i = '0, chan_full_i = '0;

   // memory, device fifo and channel register models
   dma_pkg::word_t mem [0:255];
   dma_pkg::word_t log_addr [0:255];                       // address of every memory access
   dma_pkg::word_t sink_mem [0:255];
   dma_pkg::word_t src_mem [0:255];
   logic [7:0] log_cnt, sink_cnt, src_rd, src_lim, ack_wait;
   logic [31:0] mdl_seed = 32'd56, tst_seed;
   int irq_cnt [N];
   int cycles = 0;
   logic bus_hold, full_rand, ld_en;
   dma_pkg::chan_t ld_ch;
   dma_pkg::word_t ld_madr, ld_bcr, ld_chcr;

   dma_controller dma_controller_inst (.*);

   always #50 sys_clk = ~sys_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic dma_pkg::word_t fill_word(input logic [7:0] idx);
      return 32'hC0DE_0000 ^ ({24'h0, idx} * 32'h0100_0193);
   endfunction

   always @(posedge sys_clk) begin : model
      logic [7:0] nxt;
      dma_en_i <= dma_req_o && !bus_hold;                  // memory controller grants the bus
      if (rst) begin
         for (int i = 0; i < 256; i++) mem[i] <= fill_word(8'(i));
         for (int i = 0; i < N; i++) irq_cnt[i] <= 0;
         mem_ack_i <= 1'b0;
         log_cnt <= '0;
         sink_cnt <= '0;
         src_rd <= '0;
         ack_wait <= '0;
         madr_i <= '0;
         bcr_i <= '0;
         chcr_i <= '0;
      end else begin
         mdl_seed <= xorshift(mdl_seed);
         if (mem_ack_i) begin
            mem_ack_i <= 1'b0;
            ack_wait <= {6'd0, mdl_seed[1:0]};             // next random ack delay
         end else if (mem_ren_o || mem_wen_o) begin
            if (ack_wait == 8'd0) begin
               mem_ack_i <= 1'b1;
               log_addr[log_cnt] <= mem_addr_o;
               log_cnt <= log_cnt + 8'd1;
               if (mem_wen_o) mem[mem_addr_o[9:2]] <= mem_wdata_o;
               mem_rdata_i <= mem[mem_addr_o[9:2]];
            end else begin
               ack_wait <= ack_wait - 8'd1;
            end
         end
         nxt = src_rd + {7'd0, |(chan_ren_o & chan_rdy_i)};   // a read without ready pops nothing
         src_rd <= nxt;
         chan_rdy_i <= ((nxt < src_lim) && mdl_seed[9]) ? '1 : '0;
         for (int i = 0; i < N; i++) chan_rdata_i[i] <= src_mem[nxt];
         chan_full_i <= (full_rand && mdl_seed[4]) ? '1 : '0;
         for (int i = 0; i < N; i++) begin
            if (chan_wen_o[i] && !chan_full_i[i]) begin     // a full fifo drops the word
               sink_mem[sink_cnt] <= chan_wdata_o[i];
               sink_cnt <= sink_cnt + 8'd1;
            end
         end
         for (int i = 0; i < N; i++) begin
            if (madr_incr_o[i]) madr_i[i] <= madr_i[i] + 32'(`DMA_ADDR_STEP);
            if (bcr_decr_o[i])
               bcr_i[i][`DMA_BCR_CNT_LO +: 16] <= bcr_i[i][`DMA_BCR_CNT_LO +: 16] - 16'd1;
            if (chcr_clr_o[i]) chcr_i[i][`DMA_CHCR_BUSY_BIT] <= 1'b0;
            if (irq_o[i]) irq_cnt[i] <= irq_cnt[i] + 1;
         end
         if (ld_en) begin
            madr_i[ld_ch] <= ld_madr;
            bcr_i[ld_ch] <= ld_bcr;
            chcr_i[ld_ch] <= ld_chcr;
         end
      end
   end

   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout, the transfers did not complete within %0d cycles", TIMEOUT);
         $display("TEST FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic load_chan(input int ch, input dma_pkg::word_t madr, input logic [15:0] cnt,
                            input dma_pkg::word_t chcr);
      @(posedge sys_clk);
      ld_en <= 1'b1;
      ld_ch <= dma_pkg::chan_t'(ch);
      ld_madr <= madr;
      ld_bcr <= {cnt, 16'h0001};
      ld_chcr <= chcr;
      @(posedge sys_clk);
      ld_en <= 1'b0;
   endtask

   task automatic wait_idle(input int ch);
      do @(negedge sys_clk); while (chcr_i[ch][`DMA_CHCR_BUSY_BIT]);
   endtask

   task automatic write_dicr(input dma_pkg::word_t v);
      @(posedge sys_clk);
      dicr_wen_i <= 1'b1;
      dicr_wdata_i <= v;
      @(posedge sys_clk);
      dicr_wen_i <= 1'b0;
      @(negedge sys_clk);
   endtask

   task automatic reset_and_bus_test();
      @(negedge sys_clk);
      check("madr_incr_o", 32'(madr_incr_o), 32'd0);
      check("bcr_decr_o", 32'(bcr_decr_o), 32'd0);
      check("chcr_clr_o", 32'(chcr_clr_o), 32'd0);
      check("irq_o", 32'(irq_o), 32'd0);
      check("chan_ren_o", 32'(chan_ren_o), 32'd0);
      check("chan_wen_o", 32'(chan_wen_o), 32'd0);
      check("dma_done_o", 32'(dma_done_o), 32'd0);
      check("dicr_o", dicr_o, 32'd0);
      @(posedge sys_clk);
      bus_hold <= 1'b1;
      load_chan(2, 32'h240, 16'd1, TO_DEV);
      repeat (20) begin
         @(negedge sys_clk);
         check("dma_req_o", 32'(dma_req_o), 32'd1);
         check("mem_ren_o", 32'(mem_ren_o), 32'd0);
         check("mem_wen_o", 32'(mem_wen_o), 32'd0);
      end
      @(posedge sys_clk);
      bus_hold <= 1'b0;
      wait_idle(2);
      check("sink_word", sink_mem[sink_cnt - 8'd1], fill_word(8'd144));
   endtask

   task automatic dev_to_mem_block();
      logic [7:0] base;
      int irq0;
      base = src_lim;
      irq0 = irq_cnt[1];
      for (int k = 0; k < 6; k++) begin
         tst_seed = xorshift(tst_seed);
         src_mem[8'(base + k)] = tst_seed;
      end
      @(posedge sys_clk);
      src_lim <= base + 8'd6;
      load_chan(1, 32'h100, 16'd6, TO_MEM);
      wait_idle(1);
      for (int k = 0; k < 6; k++) check("mem", mem[8'(64 + k)], src_mem[8'(base + k)]);
      check("bcr_cnt", 32'(bcr_i[1][`DMA_BCR_CNT_LO +: 16]), 32'd0);
      check("chcr_busy", 32'(chcr_i[1][`DMA_CHCR_BUSY_BIT]), 32'd0);
      check("irq_count", irq_cnt[1] - irq0, 32'd1);
   endtask

   task automatic mem_to_dev_block();
      logic [7:0] base;
      base = sink_cnt;
      @(posedge sys_clk);
      full_rand <= 1'b1;                                  // device stalls at random
      load_chan(2, 32'h200, 16'd5, TO_DEV);
      wait_idle(2);
      @(posedge sys_clk);
      full_rand <= 1'b0;
      check("sink_count", 32'(sink_cnt - base), 32'd5);
      for (int k = 0; k < 5; k++) begin
         check("sink_word", sink_mem[8'(base + k)], fill_word(8'(128 + k)));
      end
   endtask

   task automatic prio_case(input logic [2:0] p0, input logic e0, input logic [2:0] p3,
                            input logic e3);
      int win;
      logic [7:0] base;
      win = (e0 && (!e3 || p0 <= p3)) ? 0 : 3;             // lower value wins and a tie goes to ch0
      @(posedge sys_clk);
      bus_hold <= 1'b1;
      dpcr_i <= {16'h0, e3, p3, 8'h00, e0, p0};
      load_chan(0, 32'h300, 16'd1, TO_DEV);
      load_chan(3, 32'h340, 16'd1, TO_DEV);
      @(negedge sys_clk);
      base = log_cnt;
      @(posedge sys_clk);
      bus_hold <= 1'b0;
      wait_idle(win);
      repeat (20) @(negedge sys_clk);
      check("first_addr", log_addr[base], (win == 3) ? 32'h340 : 32'h300);
      if (!e0) begin
         check("ch0_busy", 32'(chcr_i[0][`DMA_CHCR_BUSY_BIT]), 32'd1);
         check("access_count", 32'(log_cnt - base), 32'd1);
         load_chan(0, 32'h300, 16'd0, 32'h0);
      end else begin
         wait_idle(0);
         wait_idle(3);
      end
   endtask

   task automatic dicr_test();
      write_dicr(MASTER | EN1);
      load_chan(1, 32'h180, 16'd0, TO_MEM);
      wait_idle(1);
      repeat (3) @(negedge sys_clk);
      check("dicr_flag1", 32'(dicr_o[`DMA_DICR_FLAG_LO + 1]), 32'd1);
      check("dicr_sum", 32'(dicr_o[`DMA_DICR_SUM_BIT]), 32'd1);
      write_dicr(MASTER | EN1 | FLAG1);
      check("dicr_flag1", 32'(dicr_o[`DMA_DICR_FLAG_LO + 1]), 32'd0);
      write_dicr(MASTER);
      load_chan(1, 32'h180, 16'd0, TO_MEM);
      wait_idle(1);
      repeat (3) @(negedge sys_clk);
      check("dicr_flag1", 32'(dicr_o[`DMA_DICR_FLAG_LO + 1]), 32'd0);
      write_dicr(32'hFFFF_FFFF);
      check("dicr_14_6", 32'(dicr_o[14:6]), 32'd0);
      write_dicr(32'h0);
   endtask

   initial begin
      dpcr_i = 32'h0000_BA98;                             // all enabled with prio equal to index
      dicr_wen_i = 1'b0;
      dicr_wdata_i = '0;
      bus_hold = 1'b0;
      full_rand = 1'b0;
      ld_en = 1'b0;
      ld_ch = '0;
      ld_madr = '0;
      ld_bcr = '0;
      ld_chcr = '0;
      src_lim = '0;
      tst_seed = 32'd56;
      repeat (8) @(posedge sys_clk);
      rst <= 1'b0;
      reset_and_bus_test();
      dev_to_mem_block();
      mem_to_dev_block();
      prio_case(3'd5, 1'b1, 3'd2, 1'b1);
      prio_case(3'd4, 1'b1, 3'd4, 1'b1);
      prio_case(3'd1, 1'b0, 3'd6, 1'b1);
      @(posedge sys_clk);
      dpcr_i <= 32'h0000_BA98;
      dicr_test();
      $display("TEST OK");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_if.sv
hdl/dma_decode.sv
hdl/dma_execute.sv
hdl/dma_result.sv
hdl/dma_controller.sv
test/dma_checker.sv
test/dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dma_tb
FLIST     ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the simulator exits non-zero on any $fatal or failed assertion
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
